// ==== saturn_bus_pkg.sv ====
package saturn_bus_pkg;

  // Command codes seen on the bus while cmd_data is low.
  typedef enum logic [3:0] {
    NOP       = 4'h0,  // Idle cycle, no access pending.
    PC_READ   = 4'h2,  // Read through the program pointer.
    DP_READ   = 4'h4,  // Read through the data pointer.
    DP_WRITE  = 4'h5,  // Write through the data pointer.
    LOAD_PC   = 4'h6,  // Five address nibbles follow for pc.
    LOAD_DP   = 4'h7,  // Five address nibbles follow for dp.
    CONFIGURE = 4'h8,  // Decoded by the chips and then ignored.
    RESET     = 4'hf   // Decoded by the chips and then ignored.
  } bus_cmd_e;

  // One bus word, read as a command or as a data nibble.
  // The cmd_data line of the bus tells which view is valid.
  typedef union packed {
    bus_cmd_e   cmd;  // Valid while cmd_data is low.
    logic [3:0] nib;  // Address or data nibble while cmd_data is high.
  } bus_nibble_u;

  // Word-level operations that the host hands to the controller.
  typedef enum logic [1:0] {
    FETCH = 2'd0,  // Read one nibble through pc.
    READ  = 2'd1,  // Read one nibble through dp.
    WRITE = 2'd2   // Write one nibble through dp.
  } host_op_e;

endpackage

// ==== saturn_mem_pkg.sv ====
package saturn_mem_pkg;

  // Width of a bus address in bits.
  localparam int ADDR_W = 20;

  // Address nibbles sent after LOAD_PC or LOAD_DP, least significant first.
  localparam int ADDR_NIBBLES = 5;

  // Bottom of the ROM window.
  localparam logic [ADDR_W-1:0] ROM_BASE = 20'h00000;

  // Bottom of the RAM window, upper half of the address space.
  localparam logic [ADDR_W-1:0] RAM_BASE = 20'h80000;

  // Image loaded into the ROM chip at start of simulation.
  localparam string ROM_FILE = "rom.hex";

endpackage

// ==== saturn_bus_if.sv ====
`timescale 1ns/1ps

// One nibble bus between the controller and a single memory chip.
interface saturn_bus_if;
  import saturn_bus_pkg::*;

  logic        cmd_data;  // Low for a command nibble, high for data.
  bus_nibble_u to_dev;    // Nibble from the controller to the chip.
  logic [3:0]  from_dev;  // Read data coming back from the chip.
  logic        drive;     // Chip owns the read data this cycle.

  // The controller drives the nibble stream and samples the read back.
  modport ctrl (
    output cmd_data,
    output to_dev,
    input  from_dev,
    input  drive
  );

  // The chip follows the nibble stream and answers reads.
  modport dev (
    input  cmd_data,
    input  to_dev,
    output from_dev,
    output drive
  );

endinterface

// ==== saturn_bus_ctrl.sv ====
`timescale 1ns/1ps

module saturn_bus_ctrl (
  input  logic                              i_bus_strobe,
  input  logic                              i_reset,
  input  logic                              i_req_valid,
  output logic                              o_req_ready,
  input  saturn_bus_pkg::host_op_e          i_req_op,
  input  logic [saturn_mem_pkg::ADDR_W-1:0] i_req_addr,
  input  logic [3:0]                        i_req_data,
  output logic                              o_rsp_valid,
  output logic [3:0]                        o_rsp_data,
  saturn_bus_if.ctrl                        rom_bus,
  saturn_bus_if.ctrl                        ram_bus
);
  import saturn_bus_pkg::*;
  import saturn_mem_pkg::*;

  localparam logic [2:0] S_IDLE  = 3'd0;  // Waiting for a host request.
  localparam logic [2:0] S_CMD   = 3'd1;  // LOAD_PC or LOAD_DP on the bus.
  localparam logic [2:0] S_ADDR  = 3'd2;  // Shifting out the address nibbles.
  localparam logic [2:0] S_DATA  = 3'd3;  // Read data cycle for the chips.
  localparam logic [2:0] S_RSP   = 3'd4;  // Chips present data, response is formed.
  localparam logic [2:0] S_WCMD  = 3'd5;  // DP_WRITE command on the bus.
  localparam logic [2:0] S_WDATA = 3'd6;  // Write data nibble on the bus.

  logic [2:0]        state;     // Current sequencer state.
  logic [2:0]        nib_cnt;   // Counts the address nibbles sent so far.
  host_op_e          op_q;      // Operation of the request in flight.
  logic [ADDR_W-1:0] addr_sr;   // Address, shifted right one nibble per cycle.
  logic [3:0]        data_q;    // Write data of the request in flight.
  logic              cmd_data;  // Shared cmd_data level for both buses.
  bus_nibble_u       bus_word;  // Shared nibble for both buses.
  logic              accept;    // Request handshake on this edge.

  assign o_req_ready = (state == S_IDLE);  // Only one request in flight.
  assign accept      = i_req_valid && o_req_ready;

  // Both chips see the same nibble stream.
  assign rom_bus.cmd_data = cmd_data;
  assign rom_bus.to_dev   = bus_word;
  assign ram_bus.cmd_data = cmd_data;
  assign ram_bus.to_dev   = bus_word;

  // Bus word for the current state.
  always_comb begin
    cmd_data     = 1'b0;  // Idle cycles carry NOP commands.
    bus_word.cmd = NOP;
    case (state)
      S_CMD: begin
        bus_word.cmd = (op_q == FETCH) ? LOAD_PC : LOAD_DP;  // Selects the pointer.
      end
      S_ADDR: begin
        cmd_data     = 1'b1;
        bus_word.nib = addr_sr[3:0];  // Least significant nibble first.
      end
      S_DATA: begin
        cmd_data     = 1'b1;  // The chips register read data on this cycle.
        bus_word.nib = 4'h0;
      end
      S_WCMD: begin
        bus_word.cmd = DP_WRITE;
      end
      S_WDATA: begin
        cmd_data     = 1'b1;
        bus_word.nib = data_q;  // Stored by the RAM, dropped by the ROM.
      end
      default: begin
        bus_word.cmd = NOP;  // Also ends the read so the chips drop drive.
      end
    endcase
  end

  // Sequencer and response strobe.
  always_ff @(posedge i_bus_strobe) begin
    if (i_reset) begin
      state       <= S_IDLE;
      nib_cnt     <= 3'd0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= (state == S_RSP);  // One cycle per read request.
      case (state)
        S_IDLE: begin
          if (accept) state <= S_CMD;
        end
        S_CMD: begin
          state   <= S_ADDR;
          nib_cnt <= 3'd0;
        end
        S_ADDR: begin
          if (nib_cnt == 3'(ADDR_NIBBLES - 1)) begin
            state <= (op_q == WRITE) ? S_WCMD : S_DATA;  // Chips are now in read state.
          end else begin
            nib_cnt <= nib_cnt + 3'd1;
          end
        end
        S_DATA:  state <= S_RSP;
        S_RSP:   state <= S_IDLE;
        S_WCMD:  state <= S_WDATA;
        S_WDATA: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request fields and response data.
  always_ff @(posedge i_bus_strobe) begin
    if (accept) begin
      op_q    <= i_req_op;
      addr_sr <= i_req_addr;
      data_q  <= i_req_data;
    end else if (state == S_ADDR) begin
      addr_sr <= addr_sr >> 4;  // Next nibble into the low bits.
    end
    if (state == S_RSP) begin
      // Unclaimed addresses read as zero.
      o_rsp_data <= rom_bus.drive ? rom_bus.from_dev :
                    (ram_bus.drive ? ram_bus.from_dev : 4'h0);
    end
  end

  // The two windows do not overlap, so at most one chip answers a read.
  a_single_driver: assert property (@(posedge i_bus_strobe) disable iff (i_reset)
    !(rom_bus.drive && ram_bus.drive));

  // After an accept the host sees ready low for the whole request.
  a_busy_window: assert property (@(posedge i_bus_strobe) disable iff (i_reset)
    accept |=> (!o_req_ready) [*8] ##1 o_req_ready);

endmodule

// ==== saturn_rom_dev.sv ====
`timescale 1ns/1ps

module saturn_rom_dev #(
  parameter int                                ROM_BITS = 8,
  parameter logic [saturn_mem_pkg::ADDR_W-1:0] BASE     = saturn_mem_pkg::ROM_BASE
) (
  input  logic      i_bus_strobe,
  input  logic      i_reset,
  saturn_bus_if.dev bus
);
  import saturn_bus_pkg::*;
  import saturn_mem_pkg::*;

  localparam logic [ADDR_W:0] SIZE = (ADDR_W + 1)'(1) << ROM_BITS;  // Window size in nibbles.

  logic [3:0]        rom [0:2**ROM_BITS-1];  // Nibble image.
  logic [ADDR_W-1:0] local_pc;               // Chip copy of the program pointer.
  logic [ADDR_W-1:0] local_dp;               // Chip copy of the data pointer.
  bus_cmd_e          last_cmd;               // Last command, or the auto read state.
  logic [2:0]        addr_c;                 // Address nibble being loaded.
  logic [ADDR_W-1:0] ptr;                    // Pointer used by the current access.
  logic              in_win;                 // Pointer lies inside this chip.
  logic              rd_cycle;               // Data cycle of a read command.

  initial begin
    $readmemh(ROM_FILE, rom);
  end

  assign ptr      = (last_cmd == PC_READ) ? local_pc : local_dp;
  assign in_win   = (ptr >= BASE) && ({1'b0, ptr - BASE} < SIZE);
  assign rd_cycle = bus.cmd_data && ((last_cmd == PC_READ) || (last_cmd == DP_READ));

  always_ff @(posedge i_bus_strobe) begin
    if (i_reset) begin
      last_cmd  <= NOP;
      addr_c    <= 3'd0;
      local_pc  <= '0;
      local_dp  <= '0;
      bus.drive <= 1'b0;
    end else begin
      bus.drive <= rd_cycle && in_win;  // Held for a single cycle.
      if (!bus.cmd_data) begin
        last_cmd <= bus.to_dev.cmd;  // Any new command restarts address loading.
        addr_c   <= 3'd0;
      end else begin
        case (last_cmd)
          LOAD_PC, LOAD_DP: begin
            if (last_cmd == LOAD_PC) local_pc[addr_c*4 +: 4] <= bus.to_dev.nib;
            else local_dp[addr_c*4 +: 4] <= bus.to_dev.nib;
            if (addr_c == 3'(ADDR_NIBBLES - 1)) begin
              last_cmd <= (last_cmd == LOAD_PC) ? PC_READ : DP_READ;  // Auto read.
              addr_c   <= 3'd0;
            end else begin
              addr_c <= addr_c + 3'd1;
            end
          end
          PC_READ:  local_pc <= local_pc + ADDR_W'(1);
          DP_READ:  local_dp <= local_dp + ADDR_W'(1);
          DP_WRITE: local_dp <= local_dp + ADDR_W'(1);  // Writes skip the ROM.
          CONFIGURE, RESET: begin
          end
          default: begin
          end
        endcase
      end
    end
  end

  // The read data register is indexed by the low pointer bits.
  always_ff @(posedge i_bus_strobe) begin
    if (rd_cycle) bus.from_dev <= rom[ptr[ROM_BITS-1:0]];
  end

  a_addr_c_range: assert property (@(posedge i_bus_strobe) disable iff (i_reset)
    addr_c <= 3'(ADDR_NIBBLES - 1));

endmodule

// ==== saturn_ram_dev.sv ====
`timescale 1ns/1ps

module saturn_ram_dev #(
  parameter int                                RAM_BITS = 6,
  parameter logic [saturn_mem_pkg::ADDR_W-1:0] BASE     = saturn_mem_pkg::RAM_BASE
) (
  input  logic      i_bus_strobe,
  input  logic      i_reset,
  saturn_bus_if.dev bus
);
  import saturn_bus_pkg::*;
  import saturn_mem_pkg::*;

  localparam logic [ADDR_W:0] SIZE = (ADDR_W + 1)'(1) << RAM_BITS;  // Window size in nibbles.

  logic [3:0]        mem [0:2**RAM_BITS-1];  // Nibble storage.
  logic [ADDR_W-1:0] local_pc;               // Chip copy of the program pointer.
  logic [ADDR_W-1:0] local_dp;               // Chip copy of the data pointer.
  bus_cmd_e          last_cmd;               // Last command, or the auto read state.
  logic [2:0]        addr_c;                 // Address nibble being loaded.
  logic [ADDR_W-1:0] ptr;                    // Pointer used by the current access.
  logic              in_win;                 // Pointer lies inside this chip.
  logic              rd_cycle;               // Data cycle of a read command.
  logic              wr_cycle;               // Data cycle of DP_WRITE.

  assign ptr      = (last_cmd == PC_READ) ? local_pc : local_dp;  // dp for writes.
  assign in_win   = (ptr >= BASE) && ({1'b0, ptr - BASE} < SIZE);
  assign rd_cycle = bus.cmd_data && ((last_cmd == PC_READ) || (last_cmd == DP_READ));
  assign wr_cycle = bus.cmd_data && (last_cmd == DP_WRITE);

  always_ff @(posedge i_bus_strobe) begin
    if (i_reset) begin
      last_cmd  <= NOP;
      addr_c    <= 3'd0;
      local_pc  <= '0;
      local_dp  <= '0;
      bus.drive <= 1'b0;
    end else begin
      bus.drive <= rd_cycle && in_win;  // Only while answering a read.
      if (!bus.cmd_data) begin
        last_cmd <= bus.to_dev.cmd;
        addr_c   <= 3'd0;
      end else begin
        case (last_cmd)
          LOAD_PC, LOAD_DP: begin
            if (last_cmd == LOAD_PC) local_pc[addr_c*4 +: 4] <= bus.to_dev.nib;
            else local_dp[addr_c*4 +: 4] <= bus.to_dev.nib;
            if (addr_c == 3'(ADDR_NIBBLES - 1)) begin
              last_cmd <= (last_cmd == LOAD_PC) ? PC_READ : DP_READ;  // Auto read.
              addr_c   <= 3'd0;
            end else begin
              addr_c <= addr_c + 3'd1;
            end
          end
          PC_READ:  local_pc <= local_pc + ADDR_W'(1);
          DP_READ, DP_WRITE: local_dp <= local_dp + ADDR_W'(1);  // Advance after access.
          default: begin
          end
        endcase
      end
    end
  end

  // Storage is cleared by reset and written under DP_WRITE.
  always_ff @(posedge i_bus_strobe) begin
    if (i_reset) begin
      for (int i = 0; i < 2**RAM_BITS; i++) mem[i] <= 4'h0;
    end else if (wr_cycle && in_win) begin
      mem[ptr[RAM_BITS-1:0]] <= bus.to_dev.nib;  // Outside the window the write is lost.
    end
  end

  always_ff @(posedge i_bus_strobe) begin
    if (rd_cycle) bus.from_dev <= mem[ptr[RAM_BITS-1:0]];
  end

  // Drive is raised only while a read command is still the active one.
  a_drive_on_read: assert property (@(posedge i_bus_strobe) disable iff (i_reset)
    bus.drive |-> ((last_cmd == PC_READ) || (last_cmd == DP_READ)));

endmodule

// ==== saturn_bus_sys.sv ====
`timescale 1ns/1ps

module saturn_bus_sys #(
  parameter int ROM_BITS = 8,  // ROM depth as a power of two.
  parameter int RAM_BITS = 6   // RAM depth as a power of two.
) (
  input  logic                              i_bus_strobe,
  input  logic                              i_reset,
  input  logic                              i_req_valid,
  output logic                              o_req_ready,
  input  saturn_bus_pkg::host_op_e          i_req_op,
  input  logic [saturn_mem_pkg::ADDR_W-1:0] i_req_addr,
  input  logic [3:0]                        i_req_data,
  output logic                              o_rsp_valid,
  output logic [3:0]                        o_rsp_data
);
  import saturn_mem_pkg::*;

  // One bus per chip, both fed with the same nibble stream.
  saturn_bus_if rom_bus ();
  saturn_bus_if ram_bus ();

  saturn_bus_ctrl u_ctrl (
    .i_bus_strobe (i_bus_strobe),
    .i_reset      (i_reset),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req_op     (i_req_op),
    .i_req_addr   (i_req_addr),
    .i_req_data   (i_req_data),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data),
    .rom_bus      (rom_bus.ctrl),
    .ram_bus      (ram_bus.ctrl)
  );

  // Image chip at the bottom of the address space.
  saturn_rom_dev #(
    .ROM_BITS (ROM_BITS),
    .BASE     (ROM_BASE)
  ) u_rom (
    .i_bus_strobe (i_bus_strobe),
    .i_reset      (i_reset),
    .bus          (rom_bus.dev)
  );

  // Scratch chip in the upper half.
  saturn_ram_dev #(
    .RAM_BITS (RAM_BITS),
    .BASE     (RAM_BASE)
  ) u_ram (
    .i_bus_strobe (i_bus_strobe),
    .i_reset      (i_reset),
    .bus          (ram_bus.dev)
  );

endmodule

// ==== tb_saturn_bus_sys.sv ====
`timescale 1ns/1ps

module tb_saturn_bus_sys;
  import saturn_bus_pkg::*;

  localparam int          SEED       = 32'hd213;
  localparam string       HEX_PATH   = "rom.hex";
  localparam int          ROM_DEPTH  = 256;         // Nibbles in the ROM window.
  localparam int          RAM_DEPTH  = 64;          // Nibbles in the RAM window.
  localparam logic [19:0] RAM_START  = 20'h80000;   // Bottom of the RAM window.
  localparam int          N_ROM      = 40;          // Random ROM reads.
  localparam int          N_PAIRS    = 12;          // Write and read back pairs per window kind.
  localparam int          N_MIX      = 100;         // Mixed random requests.
  localparam int          MAX_GAP    = 3;           // Longest idle gap before a request.
  localparam int          REQ_CYCLES = 9;           // Accept to accept with valid held.
  localparam int          TOTAL      = N_ROM + 6 * N_PAIRS + N_MIX;
  localparam int          TIMEOUT_CYCLES = TOTAL * (REQ_CYCLES + MAX_GAP) + 110;

  logic        bus_strobe;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  host_op_e    req_op;
  logic [19:0] req_addr;
  logic [3:0]  req_data;
  logic        rsp_valid;
  logic [3:0]  rsp_data;

  logic [3:0]  rom_model [0:ROM_DEPTH-1];  // Copy of the hex image.
  logic [3:0]  ram_model [0:RAM_DEPTH-1];  // Expected RAM contents.
  int unsigned due_q [$];                  // Sample cycle of each awaited response.
  logic [3:0]  data_q [$];                 // Expected nibble of each awaited response.
  int unsigned cycle = 0;                  // Samples since reset was released.
  int unsigned busy_until = 0;             // Last sample where ready must be low.
  int unsigned reads_sent = 0;             // FETCH and READ requests handed over by the driver.
  int unsigned responses = 0;              // Response strobes seen by the monitor.
  int unsigned errors = 0;

  saturn_bus_sys #(.ROM_BITS(8), .RAM_BITS(6)) dut0 (
    .i_bus_strobe (bus_strobe),
    .i_reset      (reset),
    .i_req_valid  (req_valid),
    .o_req_ready  (req_ready),
    .i_req_op     (req_op),
    .i_req_addr   (req_addr),
    .i_req_data   (req_data),
    .o_rsp_valid  (rsp_valid),
    .o_rsp_data   (rsp_data)
  );

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  function automatic logic in_ram(logic [19:0] addr);
    return (addr >= RAM_START) && (addr < RAM_START + 20'(RAM_DEPTH));
  endfunction

  // Memory map as the host sees it; unclaimed space reads zero.
  function automatic logic [3:0] model_read(logic [19:0] addr);
    if (addr < 20'(ROM_DEPTH)) return rom_model[addr[7:0]];
    if (in_ram(addr)) return ram_model[addr[5:0]];
    return 4'h0;
  endfunction

  function automatic logic [19:0] rom_addr();
    return 20'($urandom % ROM_DEPTH);
  endfunction

  function automatic logic [19:0] ram_addr();
    return RAM_START + 20'($urandom % RAM_DEPTH);
  endfunction

  // Either the gap between the windows or the space above the RAM.
  function automatic logic [19:0] open_addr();
    if ($urandom % 2 == 0) return 20'h00100 + 20'($urandom % 32'h7ff00);
    return RAM_START + 20'(RAM_DEPTH) + 20'($urandom % 32'h7ffc0);
  endfunction

  function automatic logic [19:0] any_addr();
    case ($urandom % 3)
      0:       return rom_addr();
      1:       return ram_addr();
      default: return open_addr();
    endcase
  endfunction

  // Optional idle gap, then the request is held until the handshake edge.
  task automatic send_request(host_op_e op, logic [19:0] addr, logic [3:0] data);
    int unsigned gap;
    gap = $urandom % (MAX_GAP + 1);
    if (gap != 0) begin
      req_valid <= 1'b0;
      repeat (gap) @(posedge bus_strobe);
    end
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_data  <= data;
    @(posedge bus_strobe);
    while (!req_ready) @(posedge bus_strobe);  // Valid and fields stay put meanwhile.
    if (op != WRITE) reads_sent++;  // Each of these owes the host one response.
  endtask

  initial begin
    bus_strobe = 1'b0;
    forever #2 bus_strobe = ~bus_strobe;
  end

  initial begin
    #(TIMEOUT_CYCLES * 4);
    $display("The run did not finish within %0d cycles.", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired.");
  end

  // The monitor reads the values that were sampled by the edge.
  always @(posedge bus_strobe) begin
    if (!reset) begin
      cycle++;
      check_value("o_req_ready", cycle > busy_until, req_ready);  // Low through the request.
      check_value("o_rsp_valid", due_q.size() != 0 && due_q[0] == cycle, rsp_valid);
      if (rsp_valid) begin
        responses++;
        check_value("o_rsp_data", data_q.pop_front(), rsp_data);
        void'(due_q.pop_front());
      end
      if (req_valid && req_ready) begin
        busy_until = cycle + 8;  // Ready comes back on the ninth sample.
        if (req_op == WRITE) begin
          if (in_ram(req_addr)) ram_model[req_addr[5:0]] = req_data;  // Others are dropped.
        end else begin
          due_q.push_back(cycle + 9);  // Registered by the edge eight after accept.
          data_q.push_back(model_read(req_addr));
        end
      end
    end
  end

  initial begin
    logic [19:0] addr;
    logic [3:0]  data;
    void'($urandom(SEED));
    reset     = 1'b1;
    req_valid = 1'b0;
    req_op    = FETCH;
    req_addr  = 20'h0;
    req_data  = 4'h0;
    $readmemh(HEX_PATH, rom_model);
    for (int i = 0; i < RAM_DEPTH; i++) ram_model[i] = 4'h0;
    repeat (10) @(posedge bus_strobe);
    reset <= 1'b0;
    repeat (N_ROM) send_request(($urandom % 2 == 0) ? FETCH : READ, rom_addr(), 4'h0);
    // Each write is read back. RAM goes first, then the ROM, then unclaimed space.
    for (int k = 0; k < 3 * N_PAIRS; k++) begin
      case (k / N_PAIRS)
        0:       addr = ram_addr();
        1:       addr = rom_addr();
        default: addr = open_addr();
      endcase
      data = 4'($urandom);
      send_request(WRITE, addr, data);
      send_request(READ, addr, 4'h0);
    end
    repeat (N_MIX) send_request(host_op_e'(2'($urandom % 3)), any_addr(), 4'($urandom));
    req_valid <= 1'b0;
    @(negedge bus_strobe);
    while (due_q.size() != 0) @(negedge bus_strobe);
    repeat (12) @(negedge bus_strobe);  // A stray response would show up in here.
    check_value("response_count", reads_sent, responses);
    if (errors == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "%0d checks failed.", errors);
    end
  end

endmodule

// ==== saturn_bus_sys.f ====
saturn_bus_pkg.sv
saturn_mem_pkg.sv
saturn_bus_if.sv
saturn_bus_ctrl.sv
saturn_rom_dev.sv
saturn_ram_dev.sv
saturn_bus_sys.sv
tb_saturn_bus_sys.sv

// ==== rom.hex ====
// ROM image: one hex nibble per entry, 16 entries per line, from address 0x00 upward.
3 a 0 f 7 c 2 9 e 1 5 b 8 4 d 6
9 2 e 7 0 b 4 f 1 c 6 3 a 8 5 d
c 5 1 8 f 3 9 6 b 0 e 4 7 2 a 1
6 f 3 b 2 8 d 0 5 a 1 e 4 9 c 7
0 8 b 4 d 1 6 a 3 f 7 c 2 e 9 5
e 3 7 1 a 5 0 c 8 6 b 2 f 4 1 9
5 d 9 2 6 e 3 7 0 b 4 8 c 1 f a
b 1 4 e 8 0 a 3 6 d 2 9 5 7 0 c
7 c 6 0 3 9 f 5 d 2 8 1 e b 4 3
2 6 f a 1 4 7 b 9 e 0 d 3 5 8 0
d 0 2 5 b 7 1 e 4 8 c 6 9 0 3 f
1 9 8 3 e 2 c 4 a 7 5 0 b 6 d 2
f 4 d 6 0 a 8 1 2 5 9 e 1 3 7 b
4 b 0 9 5 f 2 8 c 3 1 7 6 a e 0
8 7 a c 4 3 e 2 f 9 6 5 0 d 2 4
a e 5 d 9 6 b 1 7 4 3 f d 0 6 8

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="TESTS FAILED"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_saturn_bus_sys -f saturn_bus_sys.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/Vtb_saturn_bus_sys > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Simulation failed, see $LOG."
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status."
  exit 1
fi

echo "Simulation passed."
exit 0
